// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
TOP       := tb_rob_core
FILELIST  := sources.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: arch_regfile.sv
/* architectural register file, 32 x 64
   written by retiring entries, x0 reads as zero */
module arch_regfile (
    input  logic           clk,
    input  logic           reset,
    commit_if.sink         commit,
    input  rob_pkg::areg_t rd_reg,
    output rob_pkg::data_t rd_value
);
    import rob_pkg::*;

    localparam int num_regs = 1 << areg_w;

    data_t regs [num_regs];

    logic wr_en;

    // writes to x0 are dropped, so it stays zero from reset
    assign wr_en = commit.commit_valid && (commit.commit_dest != '0);

    ////////////////////////////////////////
    // commit write port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;        // committed state starts at zero
            end
        end else if (wr_en) begin
            regs[commit.commit_dest] <= commit.commit_value;
        end
    end

    // read is combinational, sees the new value the cycle after commit
    assign rd_value = regs[rd_reg];

endmodule

// File: isa_pkg.sv
/* isa definitions for the rv64 subset
   major opcodes and the commit-class rules that sort them at retirement */
package isa_pkg;

    localparam int num_xregs = 32;             // integer registers, x0..x31

    typedef logic [6:0] opcode_t;              // major opcode, inst[6:0]

    ////////////////////////////////////////
    // major opcodes
    ////////////////////////////////////////
    localparam opcode_t op_load   = 7'b0000011; // lb .. ld
    localparam opcode_t op_store  = 7'b0100011; // sb .. sd
    localparam opcode_t op_op_imm = 7'b0010011; // addi, slti, shifts by imm
    localparam opcode_t op_op     = 7'b0110011; // reg-reg alu
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011; // beq .. bgeu

    // result goes to the register file at commit
    function automatic logic writes_reg(opcode_t op);
        return (op == op_load)  || (op == op_op_imm) || (op == op_op) ||
               (op == op_lui)   || (op == op_auipc)  || (op == op_jal) ||
               (op == op_jalr);
    endfunction

    // only stores touch memory, the cdb value is the address
    function automatic logic writes_mem(opcode_t op);
        return op == op_store;
    endfunction

    function automatic logic is_branch(opcode_t op);
        return op == op_branch;                 // conditional only, jumps never flush
    endfunction

endpackage

// File: map_table.sv
/* register map table
   maps each architectural register to the rob tag of its newest producer */
module map_table (
    input  logic              clk,
    input  logic              reset,
    rename_if.sink            rename,
    commit_if.sink            commit,
    input  rob_pkg::areg_t    src_reg,
    output logic              src_busy,
    output rob_pkg::rob_tag_t src_tag
);
    import rob_pkg::*;
    import isa_pkg::*;

    logic     busy [num_xregs];   // value still in flight in the rob
    rob_tag_t tag  [num_xregs];   // producer entry while busy

    logic alloc_hit;              // rename of a real destination
    logic commit_hit;             // retiring entry is still the newest producer

    // x0 is hardwired, never renamed
    assign alloc_hit = rename.alloc_valid && rename.alloc_writes_reg &&
                       (rename.alloc_dest != '0);

    // a newer rename of the same register keeps its busy bit
    assign commit_hit = commit.commit_valid && busy[commit.commit_dest] &&
                        (tag[commit.commit_dest] == commit.commit_tag);

    ////////////////////////////////////////
    // busy bits
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || commit.flush) begin
            for (int i = 0; i < num_xregs; i++) begin
                busy[i] <= 1'b0;              // everything architectural again
            end
        end else begin
            if (commit_hit) begin
                busy[commit.commit_dest] <= 1'b0;
            end
            if (alloc_hit) begin
                busy[rename.alloc_dest] <= 1'b1;  // last write wins over the commit clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_hit) begin
            tag[rename.alloc_dest] <= rename.alloc_tag;
        end
    end

    // source lookup for the operand read
    assign src_busy = busy[src_reg];
    assign src_tag  = tag[src_reg];

endmodule

// File: rob.sv
/* re-order buffer, 32 entries
   allocates at dispatch, captures cdb results and retires in program order,
   with a four-phase store handshake and a full flush on a mispredicted branch */
module rob (
    input  logic              clk,
    input  logic              reset,
    // dispatch, four-phase
    input  logic              dispatch_req,
    input  isa_pkg::opcode_t  dispatch_opcode,
    input  rob_pkg::areg_t    dispatch_dest,
    output logic              dispatch_ack,
    output rob_pkg::rob_tag_t dispatch_tag,
    // common data bus, single-cycle pulse
    input  logic              cdb_valid,
    input  rob_pkg::rob_tag_t cdb_tag,
    input  rob_pkg::data_t    cdb_value,
    input  logic              cdb_mispredict,
    // store commit, four-phase
    output logic              store_req,
    input  logic              store_ack,
    output rob_pkg::data_t    store_addr,
    // status
    output logic              rob_full,
    output logic              rob_empty,
    output logic              flush_out,
    rename_if.source          rename,
    commit_if.source          commit
);
    import rob_pkg::*;
    import isa_pkg::*;

    // store handshake at the head
    typedef enum logic [1:0] {
        ST_IDLE,      // no store in flight
        ST_REQ,       // req high, waiting for ack
        ST_RELEASE    // req dropped, waiting for ack to fall
    } store_state_t;

    entry_state_t state   [rob_depth];
    opcode_t      op      [rob_depth];
    areg_t        dest    [rob_depth];
    data_t        value   [rob_depth];
    logic         mispred [rob_depth];  // set by the cdb, only meaningful on branches

    rob_ptr_t     head;
    rob_ptr_t     tail;
    rob_tag_t     head_idx;
    rob_tag_t     tail_idx;
    store_state_t st_state;

    logic accept;       // dispatch allocates at this edge
    logic cdb_hit;      // cdb targets a BUSY entry
    logic head_ready;
    logic head_store;   // ready store waiting at the head
    logic flush_now;
    logic retire_now;   // non-store, non-flush retire
    logic store_done;

    ////////////////////////////////////////
    // pointers and head decode
    ////////////////////////////////////////
    assign head_idx  = head[tag_w-1:0];
    assign tail_idx  = tail[tag_w-1:0];
    assign rob_empty = (head == tail);
    assign rob_full  = (head_idx == tail_idx) && (head[tag_w] != tail[tag_w]);

    assign head_ready = (state[head_idx] == READY);        // empty slots never read READY
    assign head_store = head_ready && writes_mem(op[head_idx]);
    assign flush_now  = head_ready && is_branch(op[head_idx]) && mispred[head_idx];
    assign retire_now = head_ready && !head_store && !flush_now;
    assign store_done = (st_state == ST_RELEASE) && !store_ack;

    // hold off dispatch on the flush edge, the new entry would be younger anyway
    assign accept  = dispatch_req && !dispatch_ack && !rob_full && !flush_now;
    assign cdb_hit = cdb_valid && (state[cdb_tag] == BUSY);  // stale tags dropped

    assign store_req = (st_state == ST_REQ);

    // rename side, taken by the map table at the allocating edge
    assign rename.alloc_valid      = accept;
    assign rename.alloc_dest       = dispatch_dest;
    assign rename.alloc_tag        = tail_idx;
    assign rename.alloc_writes_reg = writes_reg(dispatch_opcode);

    // commit side, straight from the head entry
    assign commit.commit_valid = retire_now && writes_reg(op[head_idx]);
    assign commit.commit_dest  = dest[head_idx];
    assign commit.commit_tag   = head_idx;
    assign commit.commit_value = value[head_idx];
    assign commit.flush        = flush_now;

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            dispatch_ack <= 1'b0;
            st_state     <= ST_IDLE;
            flush_out    <= 1'b0;
            for (int i = 0; i < rob_depth; i++) begin
                state[i] <= EMPTY;
            end
        end else begin
            flush_out <= flush_now;                // one-cycle pulse after the flush edge

            // dispatch ack, drops one edge after req falls
            if (accept) begin
                dispatch_ack    <= 1'b1;
                state[tail_idx] <= BUSY;
                tail            <= tail + 1'b1;
            end else if (dispatch_ack && !dispatch_req) begin
                dispatch_ack <= 1'b0;
            end

            if (cdb_hit) begin
                state[cdb_tag] <= READY;
            end

            // store handshake
            case (st_state)
                ST_IDLE:    if (head_store) st_state <= ST_REQ;
                ST_REQ:     if (store_ack)  st_state <= ST_RELEASE;
                ST_RELEASE: if (!store_ack) st_state <= ST_IDLE;
                default:    st_state <= ST_IDLE;
            endcase

            // one retire per cycle, a pending store blocks everything behind it
            if (retire_now || store_done) begin
                state[head_idx] <= EMPTY;
                head            <= head + 1'b1;
            end

            // mispredict at the head, discard every entry
            if (flush_now) begin
                for (int i = 0; i < rob_depth; i++) begin
                    state[i] <= EMPTY;
                end
                head <= tail;
            end
        end
    end

    ////////////////////////////////////////
    // entry payload
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            op[tail_idx]      <= dispatch_opcode;
            dest[tail_idx]    <= dispatch_dest;
            mispred[tail_idx] <= 1'b0;
            dispatch_tag      <= tail_idx;          // held while ack is high
        end
        if (cdb_hit) begin
            value[cdb_tag]   <= cdb_value;
            mispred[cdb_tag] <= cdb_mispredict;
        end
        if ((st_state == ST_IDLE) && head_store) begin
            store_addr <= value[head_idx];          // steady for the whole handshake
        end
    end

endmodule

// File: rob_core.sv
/* commit end of the out-of-order core
   rob, rename map and architectural register file behind plain ports */
module rob_core (
    input  logic              clk,
    input  logic              reset,
    // dispatch
    input  logic              dispatch_req,
    input  isa_pkg::opcode_t  dispatch_opcode,
    input  rob_pkg::areg_t    dispatch_dest,
    output logic              dispatch_ack,
    output rob_pkg::rob_tag_t dispatch_tag,
    // cdb
    input  logic              cdb_valid,
    input  rob_pkg::rob_tag_t cdb_tag,
    input  rob_pkg::data_t    cdb_value,
    input  logic              cdb_mispredict,
    // store commit
    output logic              store_req,
    input  logic              store_ack,
    output rob_pkg::data_t    store_addr,
    // operand lookup
    input  rob_pkg::areg_t    src_reg,
    output logic              src_busy,
    output rob_pkg::rob_tag_t src_tag,
    output rob_pkg::data_t    src_value,
    // status
    output logic              rob_full,
    output logic              rob_empty,
    output logic              flush_out
);

    rename_if rename_bus ();
    commit_if commit_bus ();

    ////////////////////////////////////////
    // re-order buffer
    ////////////////////////////////////////
    rob i_rob (
        .clk             (clk),
        .reset           (reset),
        .dispatch_req    (dispatch_req),
        .dispatch_opcode (dispatch_opcode),
        .dispatch_dest   (dispatch_dest),
        .dispatch_ack    (dispatch_ack),
        .dispatch_tag    (dispatch_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_mispredict  (cdb_mispredict),
        .store_req       (store_req),
        .store_ack       (store_ack),
        .store_addr      (store_addr),
        .rob_full        (rob_full),
        .rob_empty       (rob_empty),
        .flush_out       (flush_out),
        .rename          (rename_bus.source),
        .commit          (commit_bus.source)
    );

    // src_reg drives both lookups, busy/tag from the map and value from the regfile
    map_table i_map_table (
        .clk      (clk),
        .reset    (reset),
        .rename   (rename_bus.sink),
        .commit   (commit_bus.sink),
        .src_reg  (src_reg),
        .src_busy (src_busy),
        .src_tag  (src_tag)
    );

    arch_regfile i_arch_regfile (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit_bus.sink),
        .rd_reg   (src_reg),
        .rd_value (src_value)
    );

endmodule

// File: rob_ifs.sv
/* rename and commit buses between the rob and its neighbours
   rename carries new allocations, commit carries the retiring head entry */

////////////////////////////////////////
// rename bus, rob to map table
////////////////////////////////////////
interface rename_if;
    import rob_pkg::*;

    logic     alloc_valid;       // pulse on the allocating edge
    areg_t    alloc_dest;        // architectural destination
    rob_tag_t alloc_tag;         // entry that now produces alloc_dest
    logic     alloc_writes_reg;  // opcode has a register result

    modport source (
        output alloc_valid, alloc_dest, alloc_tag, alloc_writes_reg
    );
    modport sink (
        input  alloc_valid, alloc_dest, alloc_tag, alloc_writes_reg
    );
endinterface

////////////////////////////////////////
// commit bus, rob to map table and regfile
////////////////////////////////////////
interface commit_if;
    import rob_pkg::*;

    logic     commit_valid;      // register-writing entry retires this cycle
    areg_t    commit_dest;
    rob_tag_t commit_tag;        // head entry, lets the map table spot stale renames
    data_t    commit_value;
    logic     flush;             // mispredicted branch retires, drop all younger state

    modport source (
        output commit_valid, commit_dest, commit_tag, commit_value, flush
    );
    modport sink (
        input  commit_valid, commit_dest, commit_tag, commit_value, flush
    );
endinterface

// File: rob_pkg.sv
/* re-order buffer definitions
   buffer depth, tag and pointer widths, register and data types */
package rob_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int rob_depth = 32;                 // entries in the buffer
    localparam int tag_w     = $clog2(rob_depth);  // 5 bits of entry index
    localparam int areg_w    = 5;                  // architectural register number
    localparam int data_w    = 64;

    typedef logic [tag_w-1:0]  rob_tag_t;   // names one rob entry
    typedef logic [tag_w:0]    rob_ptr_t;   // head/tail, msb is the wrap bit
    typedef logic [areg_w-1:0] areg_t;
    typedef logic [data_w-1:0] data_t;      // result value or store address

    // life of an entry
    //   EMPTY  free slot
    //   BUSY   allocated, waiting for its cdb broadcast
    //   READY  result captured, may retire at the head
    typedef enum logic [1:0] {
        EMPTY,
        BUSY,
        READY
    } entry_state_t;

endpackage

// File: sources.f
isa_pkg.sv
rob_pkg.sv
rob_ifs.sv
rob.sv
map_table.sv
arch_regfile.sv
rob_core.sv
tb_rob_core.sv

// File: tb_rob_core.sv
/* testbench for the rob commit end
   directed tests for rename, in-order commit, stores, back-pressure and flush */
module tb_rob_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rob_pkg::*;
    import isa_pkg::*;

    logic     clk = 1'b0;
    logic     reset, dispatch_req, dispatch_ack, cdb_valid, cdb_mispredict;
    logic     store_req, store_ack, src_busy, rob_full, rob_empty, flush_out;
    opcode_t  dispatch_opcode;
    areg_t    dispatch_dest, src_reg;
    rob_tag_t dispatch_tag, cdb_tag, src_tag;
    rob_tag_t next_tag;                   // old tail, the tag the next dispatch gets
    data_t    cdb_value, store_addr, src_value;
    data_t    exp_reg [32];               // committed register state the tests expect
    int       errors, tests, failed_tests, test_start;

    rob_core i_dut (.*);

    always #10 clk = ~clk;                // 20 ns period

    ////////////////////////////////////////
    // checker and driver tasks
    ////////////////////////////////////////
    task automatic check(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic lookup(input areg_t r);
        @(negedge clk);
        src_reg = r;
        #1;                               // let the combinational read settle
    endtask

    // not busy, and holding the committed value
    task automatic check_reg(input int r);
        lookup(areg_t'(r));
        check($sformatf("x%0d src_busy", r), data_t'(src_busy), '0);
        check($sformatf("x%0d src_value", r), src_value, exp_reg[r]);
    endtask

    task automatic wait_ack(input int limit, output bit seen);
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            seen = dispatch_ack;
        end
    endtask

    task automatic dispatch_start(input opcode_t op, input areg_t d, input int limit,
                                  output bit seen);
        @(negedge clk);
        dispatch_req    = 1'b1;
        dispatch_opcode = op;             // held steady until ack
        dispatch_dest   = d;
        wait_ack(limit, seen);
    endtask

    // tag checked while ack is high, then the return leg of the handshake
    task automatic dispatch_finish(output rob_tag_t tag);
        bit low;
        tag = next_tag;
        check("dispatch_tag", data_t'(dispatch_tag), data_t'(next_tag));
        next_tag     = next_tag + 1'b1;
        dispatch_req = 1'b0;
        low          = 1'b0;
        for (int i = 0; i < 10 && !low; i++) begin
            @(negedge clk);
            low = !dispatch_ack;
        end
        if (!low) begin
            $display("dispatch_ack stayed high after dispatch_req dropped");
            errors++;
        end
    endtask

    task automatic do_dispatch(input opcode_t op, input areg_t d, output rob_tag_t tag);
        bit seen;
        dispatch_start(op, d, 10, seen);
        if (seen) begin
            dispatch_finish(tag);
        end else begin
            $display("dispatch of opcode %h got no ack within 10 cycles", op);
            errors++;
            dispatch_req = 1'b0;
            tag          = '0;
        end
    endtask

    task automatic cdb_write(input rob_tag_t tag, input data_t v, input logic mp);
        @(negedge clk);
        cdb_valid      = 1'b1;            // single-cycle broadcast
        cdb_tag        = tag;
        cdb_value      = v;
        cdb_mispredict = mp;
        @(negedge clk);
        cdb_valid      = 1'b0;
        cdb_mispredict = 1'b0;
    endtask

    task automatic wait_commit_idle();
        bit idle;
        idle = 1'b0;
        for (int i = 0; i < 100 && !idle; i++) begin
            @(negedge clk);
            idle = rob_empty;
        end
        if (!idle) begin
            $display("rob did not drain within 100 cycles");
            errors++;
        end
    endtask

    // memory side of the store handshake, random latency before ack
    task automatic store_responder(input data_t addr);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < 20 && !seen; i++) begin
            @(negedge clk);
            seen = store_req;
        end
        if (!seen) begin
            $display("store_req never rose for a ready store at the head");
            errors++;
        end else begin
            check("store_addr", store_addr, addr);
            repeat ($urandom % 6) @(negedge clk);
            store_ack = 1'b1;
            for (int i = 0; i < 20 && seen; i++) begin
                @(negedge clk);
                seen = store_req;         // req falls once ack is seen
            end
            store_ack = 1'b0;
            if (seen) begin
                $display("store_req stayed high after store_ack");
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start) begin
            $display("-- %s: ok", name);
        end else begin
            failed_tests++;
            $display("-- %s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic reset_values();
        check("dispatch_ack", data_t'(dispatch_ack), '0);
        check("store_req", data_t'(store_req), '0);
        check("flush_out", data_t'(flush_out), '0);
        check("rob_full", data_t'(rob_full), '0);
        check("rob_empty", data_t'(rob_empty), 64'h1);
        check_reg(0);
        check_reg(1);
        check_reg(17);
        check_reg(31);
        end_test("reset values");
    endtask

    task automatic alu_rename_commit();
        rob_tag_t tags [3];
        data_t    v;
        for (int i = 0; i < 3; i++) begin
            do_dispatch(op_op, areg_t'(i + 1), tags[i]);
            lookup(areg_t'(i + 1));       // renamed to the new entry
            check("src_busy after rename", data_t'(src_busy), 64'h1);
            check("src_tag after rename", data_t'(src_tag), data_t'(tags[i]));
        end
        for (int i = 0; i < 3; i++) begin
            v = {$urandom, $urandom};
            cdb_write(tags[i], v, 1'b0);
            exp_reg[i + 1] = v;
        end
        wait_commit_idle();
        for (int i = 1; i <= 3; i++) begin
            check_reg(i);
        end
        do_dispatch(op_op_imm, '0, tags[0]);        // result to x0 is dropped
        cdb_write(tags[0], 64'hdead_beef_0bad_f00d, 1'b0);
        wait_commit_idle();
        check_reg(0);
        end_test("alu rename and commit");
    endtask

    // completion in reverse order, retirement still oldest first
    task automatic in_order_commit();
        rob_tag_t ta, tb, tc;
        do_dispatch(op_op, 5'd4, ta);
        do_dispatch(op_op_imm, 5'd5, tb);
        do_dispatch(op_op, 5'd4, tc);               // newer producer of x4
        cdb_write(tc, 64'hcccc_0003, 1'b0);
        cdb_write(tb, 64'hbbbb_0002, 1'b0);
        repeat (3) begin
            @(negedge clk);
            check("rob_empty before oldest completes", data_t'(rob_empty), '0);
        end
        cdb_write(ta, 64'haaaa_0001, 1'b0);
        wait_commit_idle();
        exp_reg[4] = 64'hcccc_0003;
        exp_reg[5] = 64'hbbbb_0002;
        check_reg(4);
        check_reg(5);
        end_test("in-order commit");
    endtask

    task automatic store_commit();
        rob_tag_t t;
        data_t    addr;
        for (int k = 0; k < 2; k++) begin
            do_dispatch(op_store, 5'd2, t);         // dest field unused by stores
            addr = {$urandom, $urandom};
            cdb_write(t, addr, 1'b0);
            store_responder(addr);
            wait_commit_idle();
        end
        check("store_req after stores", data_t'(store_req), '0);
        for (int r = 1; r < 6; r++) begin
            check_reg(r);
        end
        end_test("store commit");
    endtask

    task automatic back_pressure();
        rob_tag_t tags [rob_depth];
        rob_tag_t t;
        bit       seen;
        for (int i = 0; i < rob_depth; i++) begin
            do_dispatch(op_op, 5'd7, tags[i]);
        end
        check("rob_full", data_t'(rob_full), 64'h1);
        dispatch_start(op_op, 5'd7, 8, seen);       // req held high from here
        check("dispatch_ack while full", data_t'(seen), '0);
        cdb_write(tags[0], 64'h7000, 1'b0);         // head retires and frees a slot
        wait_ack(10, seen);
        check("dispatch_ack after a slot frees", data_t'(seen), 64'h1);
        if (seen) begin
            dispatch_finish(t);
        end else begin
            dispatch_req = 1'b0;
            t            = '0;
        end
        for (int i = 1; i < rob_depth; i++) begin
            cdb_write(tags[i], 64'h7000 + i, 1'b0);
        end
        cdb_write(t, 64'h7777, 1'b0);               // youngest write to x7 wins
        wait_commit_idle();
        exp_reg[7] = 64'h7777;
        check_reg(7);
        end_test("back-pressure");
    endtask

    task automatic mispredict_flush();
        rob_tag_t t_old, t_br, t_y1, t_y2;
        bit       seen;
        do_dispatch(op_op, 5'd8, t_old);
        do_dispatch(op_branch, '0, t_br);
        do_dispatch(op_op, 5'd9, t_y1);
        do_dispatch(op_lui, 5'd10, t_y2);
        cdb_write(t_y1, 64'h9999, 1'b0);            // younger ones ready first
        cdb_write(t_y2, 64'haaaa_0000, 1'b0);
        cdb_write(t_old, 64'h8888, 1'b0);
        cdb_write(t_br, '0, 1'b1);
        seen = 1'b0;
        for (int i = 0; i < 10 && !seen; i++) begin
            @(negedge clk);
            seen = flush_out;
        end
        if (!seen) begin
            $display("flush_out never pulsed after the mispredicted branch");
            errors++;
        end
        check("rob_empty after flush", data_t'(rob_empty), 64'h1);
        @(negedge clk);
        check("flush_out one cycle", data_t'(flush_out), '0);
        exp_reg[8] = 64'h8888;
        check_reg(8);
        check_reg(9);
        check_reg(10);
        end_test("mispredict flush");
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(32'hfa02_9102));
        reset           = 1'b1;
        dispatch_req    = 1'b0;
        dispatch_opcode = op_op;
        dispatch_dest   = '0;
        cdb_valid       = 1'b0;
        cdb_tag         = '0;
        cdb_value       = '0;
        cdb_mispredict  = 1'b0;
        store_ack       = 1'b0;
        src_reg         = '0;
        next_tag        = '0;
        errors          = 0;
        tests           = 0;
        failed_tests    = 0;
        test_start      = 0;
        foreach (exp_reg[i]) begin
            exp_reg[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_values();
        alu_rename_commit();
        in_order_commit();
        store_commit();
        back_pressure();
        mispredict_flush();

        $display("%0d tests, %0d with errors, %0d failed checks", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
